//--- adder_unit.f
+incdir+include
verilog/adder_pkg.sv
verilog/knowles_tree.sv
verilog/knowles_adder.sv
verilog/add_sub_core.sv
verilog/req_ack_port.sv
verilog/adder_unit_top.sv
verif/adder_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the add/subtract unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module adder_unit_tb \
	-f adder_unit.f \
	--Mdir obj_dir \
	-o adder_unit_sim

status=0
output=$(./obj_dir/adder_unit_sim) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qx "all tests passed"; then
	echo "Simulation PASSED"
	exit 0
fi

echo "Simulation FAILED"
exit 1

//--- verif/adder_unit_tb.sv
// Testbench for the add/subtract unit with random requests checked against a reference model
`timescale 1ns/1ps
`include "adder_settings.svh"

module adder_unit_tb;

	localparam int W = `ADDER_WIDTH;
	localparam int TIMEOUT = 50;

	logic clk;
	logic rst;
	logic req;
	adder_pkg::add_req_t request;
	logic ack;
	adder_pkg::add_rsp_t response;

	int error_count;
	int test_count;
	int test_failures;
	int errors_at_start;
	bit timed_out;

	adder_unit_top UUT (
		.clk(clk),
		.rst(rst),
		.req(req),
		.request(request),
		.ack(ack),
		.response(response)
	);

	always #10 clk = ~clk;

	task automatic check_result(input string name, input logic [W-1:0] exp,
		input logic [W-1:0] act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_flags(input adder_pkg::flags_t exp, input adder_pkg::flags_t act);
		if (act !== exp) begin
			$display("[ERROR] %0t response.flags (cvzn) expected %b got %b", $time, exp, act);
			error_count++;
		end
	endtask

	task automatic expect_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
			error_count++;
		end
	endtask

	task automatic expect_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("[ERROR] %0t %s expected %0d cycles got %0d", $time, name, exp, act);
			error_count++;
		end
	endtask

	task automatic report_and_finish();
		$display("%0d tests run, %0d passed, %0d failed, %0d check errors",
			test_count, test_count - test_failures, test_failures, error_count);
		if (error_count == 0 && !timed_out) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	endtask

	task automatic give_up(input string what);
		$display("[TIMEOUT] at %0t the unit hung: %s", $time, what);
		timed_out = 1'b1;
	endtask

	task automatic start_test();
		errors_at_start = error_count;
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (error_count == errors_at_start && !timed_out) begin
			$display("PASS  %s", name);
		end else begin
			test_failures++;
			$display("FAIL  %s with %0d errors", name, error_count - errors_at_start);
		end
	endtask

	function automatic logic [W-1:0] random_word();
		logic [63:0] r;
		r = {$urandom, $urandom};
		return r[W-1:0];
	endfunction

	function automatic adder_pkg::add_req_t make_request(input adder_pkg::op_e op,
		input logic [W-1:0] a, input logic [W-1:0] b, input logic carry_in);
		adder_pkg::add_req_t r;
		r.a = a;
		r.b = b;
		r.op = op;
		r.carry_in = carry_in;
		return r;
	endfunction

	// Unsigned sum for result and carry, sign-extended sum for overflow
	function automatic adder_pkg::add_rsp_t model_response(input adder_pkg::add_req_t r);
		adder_pkg::add_rsp_t rsp;
		logic [W:0] ua;
		logic [W:0] ub;
		logic [W:0] ufull;
		logic [W:0] cin_ext;
		logic signed [W+1:0] sa;
		logic signed [W+1:0] sb;
		logic signed [W+1:0] sfull;
		logic signed [W+1:0] scin;
		logic carry;
		ua = {1'b0, r.a};
		ub = {1'b0, r.b};
		sa = $signed({{2{r.a[W-1]}}, r.a});
		sb = $signed({{2{r.b[W-1]}}, r.b});
		cin_ext = {{W{1'b0}}, r.carry_in};
		scin = $signed({{(W+1){1'b0}}, r.carry_in});
		case (r.op)
			adder_pkg::OP_ADD: begin
				ufull = ua + ub;
				carry = ufull[W];
				sfull = sa + sb;
			end
			adder_pkg::OP_SUB: begin
				ufull = ua - ub;
				carry = ~ufull[W];
				sfull = sa - sb;
			end
			adder_pkg::OP_ADC: begin
				ufull = ua + ub + cin_ext;
				carry = ufull[W];
				sfull = sa + sb + scin;
			end
			adder_pkg::OP_SBB: begin
				// Borrow is the inverse of carry_in
				ufull = ua - ub - {{W{1'b0}}, ~r.carry_in};
				carry = ~ufull[W];
				sfull = sa - sb - $signed({{(W+1){1'b0}}, ~r.carry_in});
			end
		endcase
		rsp.result = ufull[W-1:0];
		rsp.flags.carry = carry;
		rsp.flags.overflow = !(&sfull[W+1:W-1]) && (|sfull[W+1:W-1]);
		rsp.flags.zero = (ufull[W-1:0] == '0);
		rsp.flags.negative = ufull[W-1];
		return rsp;
	endfunction

	// Full four-phase transfer, checking latency and the held response
	task automatic drive_request(input adder_pkg::add_req_t r, input int hold,
		output adder_pkg::add_rsp_t rsp);
		int cycles;
		adder_pkg::add_rsp_t held;
		rsp = '0;
		if (!timed_out) begin
			request = r;
			req = 1'b1;
			cycles = 0;
			do begin
				@(negedge clk);
				cycles++;
			end while (!ack && cycles < TIMEOUT);
			if (!ack) begin
				give_up("ack did not rise after req");
			end else begin
				expect_count("ack rise latency", 2, cycles);
				held = response;
				for (int i = 0; i < hold; i++) begin
					@(negedge clk);
					expect_bit("ack during hold", 1'b1, ack);
					check_result("response.result during hold", held.result,
						response.result);
					check_flags(held.flags, response.flags);
				end
				rsp = held;
				req = 1'b0;
				cycles = 0;
				do begin
					@(negedge clk);
					cycles++;
				end while (ack && cycles < TIMEOUT);
				if (ack) begin
					give_up("ack did not fall after req was released");
				end else begin
					expect_count("ack fall latency", 1, cycles);
				end
			end
		end
	endtask

	task automatic run_and_check(input adder_pkg::add_req_t r, input int hold,
		output adder_pkg::add_rsp_t rsp);
		adder_pkg::add_rsp_t exp;
		exp = model_response(r);
		drive_request(r, hold, rsp);
		if (!timed_out) begin
			check_result("response.result", exp.result, rsp.result);
			check_flags(exp.flags, rsp.flags);
		end
	endtask

	initial begin
		adder_pkg::add_req_t r;
		adder_pkg::add_rsp_t rsp;
		adder_pkg::add_rsp_t lo;
		adder_pkg::add_rsp_t hi;
		logic [2*W-1:0] a64;
		logic [2*W-1:0] b64;
		logic [2*W:0] full64;
		logic [W-1:0] corners[7];
		adder_pkg::op_e op;

		clk = 1'b0;
		rst = 1'b1;
		req = 1'b0;
		request = '0;
		error_count = 0;
		test_count = 0;
		test_failures = 0;
		timed_out = 1'b0;
		void'($urandom(32'hd2ed));

		repeat (8) @(negedge clk);
		rst = 1'b0;

		start_test();
		@(negedge clk);
		expect_bit("ack", 1'b0, ack);
		check_result("response.result", '0, response.result);
		check_flags('0, response.flags);
		finish_test("state after reset");

		start_test();
		for (int i = 0; i < 500; i++) begin
			r = make_request(adder_pkg::OP_ADD, random_word(), random_word(),
				1'($urandom_range(1, 0)));
			run_and_check(r, 0, rsp);
		end
		finish_test("random add");

		start_test();
		for (int i = 0; i < 300; i++) begin
			r = make_request(adder_pkg::OP_SUB, random_word(), random_word(), 1'b0);
			run_and_check(r, 0, rsp);
			if (!timed_out) begin
				expect_bit("flags.carry as a >= b", r.a >= r.b, rsp.flags.carry);
			end
		end
		finish_test("random subtract");

		start_test();
		for (int i = 0; i < 300; i++) begin
			op = ($urandom_range(1, 0) != 0) ? adder_pkg::OP_ADC : adder_pkg::OP_SBB;
			r = make_request(op, random_word(), random_word(), 1'($urandom_range(1, 0)));
			run_and_check(r, 0, rsp);
		end
		// 64-bit add and subtract from two chained halves
		for (int i = 0; i < 100; i++) begin
			a64 = {random_word(), random_word()};
			b64 = {random_word(), random_word()};
			r = make_request(adder_pkg::OP_ADC, a64[W-1:0], b64[W-1:0], 1'b0);
			run_and_check(r, 0, lo);
			r = make_request(adder_pkg::OP_ADC, a64[2*W-1:W], b64[2*W-1:W], lo.flags.carry);
			run_and_check(r, 0, hi);
			full64 = {1'b0, a64} + {1'b0, b64};
			if (!timed_out) begin
				check_result("chained sum low", full64[W-1:0], lo.result);
				check_result("chained sum high", full64[2*W-1:W], hi.result);
				expect_bit("chained sum carry", full64[2*W], hi.flags.carry);
			end
			r = make_request(adder_pkg::OP_SBB, a64[W-1:0], b64[W-1:0], 1'b1);
			run_and_check(r, 0, lo);
			r = make_request(adder_pkg::OP_SBB, a64[2*W-1:W], b64[2*W-1:W], lo.flags.carry);
			run_and_check(r, 0, hi);
			full64 = {1'b0, a64} - {1'b0, b64};
			if (!timed_out) begin
				check_result("chained difference low", full64[W-1:0], lo.result);
				check_result("chained difference high", full64[2*W-1:W], hi.result);
				expect_bit("chained difference carry", ~full64[2*W], hi.flags.carry);
			end
		end
		finish_test("carry chains with adc and sbb");

		start_test();
		corners[0] = '0;
		corners[1] = '1;
		corners[2] = {{(W-1){1'b0}}, 1'b1};
		corners[3] = {1'b1, {(W-1){1'b0}}};
		corners[4] = {1'b0, {(W-1){1'b1}}};
		corners[5] = {(W/2){2'b10}};
		corners[6] = {(W/2){2'b01}};
		for (int i = 0; i < 7; i++) begin
			for (int j = 0; j < 7; j++) begin
				for (int k = 0; k < 8; k++) begin
					op = adder_pkg::op_e'(2'(k >> 1));
					r = make_request(op, corners[i], corners[j], 1'(k & 1));
					run_and_check(r, 0, rsp);
				end
			end
		end
		finish_test("corner operands");

		start_test();
		for (int i = 0; i < 100; i++) begin
			op = adder_pkg::op_e'(2'($urandom_range(3, 0)));
			r = make_request(op, random_word(), random_word(), 1'($urandom_range(1, 0)));
			run_and_check(r, int'($urandom_range(5, 0)), rsp);
		end
		finish_test("handshake timing with random hold");

		report_and_finish();
	end

endmodule

//--- verilog/adder_unit_top.sv
// Top level of the add/subtract unit joining the handshake port and the core
`timescale 1ns/1ps

module adder_unit_top (
	input logic clk,
	input logic rst,
	input logic req,
	input adder_pkg::add_req_t request,
	output logic ack,
	output adder_pkg::add_rsp_t response
);

	adder_pkg::add_req_t operand;
	adder_pkg::add_rsp_t outcome;

	req_ack_port port (
		.clk(clk),
		.rst(rst),
		.req(req),
		.request(request),
		.ack(ack),
		.response(response),
		.operand(operand),
		.outcome(outcome)
	);

	add_sub_core core (
		.clk(clk),
		.operand(operand),
		.outcome(outcome)
	);

endmodule

//--- verilog/req_ack_port.sv
// Four-phase req/ack target that captures a request and holds the response under ack
`timescale 1ns/1ps

module req_ack_port (
	input logic clk,
	input logic rst,
	input logic req,
	input adder_pkg::add_req_t request,
	output logic ack,
	output adder_pkg::add_rsp_t response,
	output adder_pkg::add_req_t operand,
	input adder_pkg::add_rsp_t outcome
);

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_COMPUTE = 2'd1,
		ST_ACK = 2'd2
	} state_e;

	state_e state;
	logic start;

	// ack is always low in idle
	assign start = (state == ST_IDLE) && req;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			ack <= 1'b0;
			response <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_COMPUTE;
					end
				end
				ST_COMPUTE: begin
					response <= outcome;
					ack <= 1'b1;
					state <= ST_ACK;
				end
				ST_ACK: begin
					// Hold everything until the requester lets go
					if (!req) begin
						ack <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
					ack <= 1'b0;
				end
			endcase
		end
	end

	// Operation stays put while the core works on it
	always_ff @(posedge clk) begin
		if (start) begin
			operand <= request;
		end
	end

	// Request was held from capture through to ack
	ack_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> $past(req, 1) && $past(req, 2));

	rsp_stable: assert property (@(posedge clk) disable iff (rst)
		$past(ack) && ack |-> $stable(response));

	// No new request before the previous ack has dropped
	req_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(req) |-> !ack);

endmodule

//--- verilog/add_sub_core.sv
// Add/subtract core with operand conditioning and condition flags
`timescale 1ns/1ps
`include "adder_settings.svh"

module add_sub_core (
	input logic clk,
	input adder_pkg::add_req_t operand,
	output adder_pkg::add_rsp_t outcome
);

	localparam int W = `ADDER_WIDTH;

	logic [W-1:0] b_in;
	logic cin;
	logic [W-1:0] sum;
	logic cout;

	// Subtraction as a plus inverted b plus carry
	always_comb begin
		b_in = operand.b;
		cin = 1'b0;
		case (operand.op)
			adder_pkg::OP_ADD: begin
				cin = 1'b0;
			end
			adder_pkg::OP_SUB: begin
				b_in = ~operand.b;
				cin = 1'b1;
			end
			adder_pkg::OP_ADC: begin
				cin = operand.carry_in;
			end
			adder_pkg::OP_SBB: begin
				// carry_in set means no borrow
				b_in = ~operand.b;
				cin = operand.carry_in;
			end
		endcase
	end

	knowles_adder adder (
		.clk(clk),
		.a(operand.a),
		.b(b_in),
		.cin(cin),
		.sum(sum),
		.cout(cout)
	);

	always_comb begin
		outcome.result = sum;
		outcome.flags.carry = cout;
		// Same input signs but result sign flipped
		outcome.flags.overflow = (operand.a[W-1] == b_in[W-1]) &&
			(sum[W-1] != operand.a[W-1]);
		outcome.flags.zero = (sum == '0);
		outcome.flags.negative = sum[W-1];
	end

	// Subtraction flags straight from the operands
	sub_flags: assert property (@(posedge clk)
		operand.op == adder_pkg::OP_SUB |->
		outcome.flags.carry == (operand.a >= operand.b) &&
		outcome.flags.zero == (operand.a == operand.b));

endmodule

//--- verilog/knowles_adder.sv
// Ling adder built around the Knowles prefix tree
`timescale 1ns/1ps
`include "adder_settings.svh"

module knowles_adder (
	input logic clk,
	input logic [`ADDER_WIDTH-1:0] a,
	input logic [`ADDER_WIDTH-1:0] b,
	input logic cin,
	output logic [`ADDER_WIDTH-1:0] sum,
	output logic cout
);

	localparam int W = `ADDER_WIDTH;

	logic [W:0] p;
	logic [W:0] g;
	logic [W:1] h;
	logic [W:1] c;

	// Slot zero carries the carry-in as a generate
	assign p = {a | b, 1'b1};
	assign g = {a & b, cin};

	knowles_tree tree (
		.clk(clk),
		.p(p),
		.g(g),
		.h(h),
		.c(c)
	);

	// With g clear h equals c and p is the half sum
	// With g set the sum bit is the carry itself
	assign sum = (p[W:1] ^ h) | (g[W:1] & c);
	assign cout = p[W] & h[W];

	// Whole adder against a plain behavioural add
	sum_check: assert property (@(posedge clk)
		{cout, sum} == ({1'b0, a} + {1'b0, b} + {{W{1'b0}}, cin}));

endmodule

//--- verilog/knowles_tree.sv
// Knowles parallel-prefix tree producing Ling pseudo-carries and true carries
`timescale 1ns/1ps
`include "adder_settings.svh"

module knowles_tree (
	input logic clk,
	input logic [`ADDER_WIDTH:0] p,
	input logic [`ADDER_WIDTH:0] g,
	output logic [`ADDER_WIDTH:1] h,
	output logic [`ADDER_WIDTH:1] c
);

	localparam int W = `ADDER_WIDTH;
	localparam int LEVELS = $clog2(W);
	localparam int DL = 1 << (LEVELS - 1);

	// Black and grey levels
	// Span doubles per level and node i ends up covering i down to 0
	for (genvar lv = 1; lv < LEVELS; lv++) begin : g_level
		localparam int D = 1 << (lv - 1);

		logic [W-1:0] hn;
		logic [W-1:0] pn;

		for (genvar i = 0; i < W; i++) begin : g_node
			if (lv == 1) begin : g_first
				// Reduced cells since a generate implies its own propagate
				if (i == 0) begin : g_seed
					assign hn[i] = g[0];
					assign pn[i] = p[0];
				end else if (i == 1) begin : g_rgrey
					assign hn[i] = g[1] | g[0];
					assign pn[i] = p[0];
				end else begin : g_rblack
					assign hn[i] = g[i] | g[i-1];
					assign pn[i] = p[i-1] & p[i-2];
				end
			end else if (i < D) begin : g_done
				assign hn[i] = g_level[lv-1].hn[i];
				assign pn[i] = g_level[lv-1].pn[i];
			end else if (i < 2 * D) begin : g_grey
				// Lower node already reaches bit 0
				logic h_hi;
				logic p_hi;
				logic h_lo;

				assign h_hi = g_level[lv-1].hn[i];
				assign p_hi = g_level[lv-1].pn[i];
				assign h_lo = g_level[lv-1].hn[i-D];
				assign hn[i] = h_hi | (p_hi & h_lo);
				assign pn[i] = p_hi;
			end else begin : g_black
				logic h_hi;
				logic p_hi;
				logic h_lo;
				logic p_lo;

				assign h_hi = g_level[lv-1].hn[i];
				assign p_hi = g_level[lv-1].pn[i];
				assign h_lo = g_level[lv-1].hn[i-D];
				assign p_lo = g_level[lv-1].pn[i-D];
				assign hn[i] = h_hi | (p_hi & h_lo);
				assign pn[i] = p_hi & p_lo;
			end
		end
	end

	// Last level
	// Bits 2k and 2k+1 share the odd lower prefix
	// The overlap of one bit is absorbed by the upper group
	logic [W-1:0] hf;

	for (genvar i = 0; i < W; i++) begin : g_last
		if (i < DL) begin : g_done
			assign hf[i] = g_level[LEVELS-1].hn[i];
		end else begin : g_share
			logic h_hi;
			logic p_hi;
			logic h_lo;

			assign h_hi = g_level[LEVELS-1].hn[i];
			assign p_hi = g_level[LEVELS-1].pn[i];
			assign h_lo = g_level[LEVELS-1].hn[(i - DL) | 1];
			assign hf[i] = h_hi | (p_hi & h_lo);
		end
	end

	// True carry into bit k+1 is p[k] and the pseudo-carry of bit k
	assign c = p[W-1:0] & hf;

	// Top pseudo-carry comes from the top carry directly
	assign h = {g[W] | c[W], hf[W-1:1]};

	ling_identity: assert property (@(posedge clk) h == (c | g[W:1]));

endmodule

//--- verilog/adder_pkg.sv
// Operation, request, flag and response types of the add/subtract unit
`include "adder_settings.svh"

package adder_pkg;

	// Arithmetic operations
	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_ADC = 2'd2,
		OP_SBB = 2'd3
	} op_e;

	// Request from the requester
	// carry_in only matters for OP_ADC and OP_SBB
	typedef struct packed {
		logic [`ADDER_WIDTH-1:0] a;
		logic [`ADDER_WIDTH-1:0] b;
		op_e op;
		logic carry_in;
	} add_req_t;

	typedef struct packed {
		logic carry;
		logic overflow;
		logic zero;
		logic negative;
	} flags_t;

	typedef struct packed {
		logic [`ADDER_WIDTH-1:0] result;
		flags_t flags;
	} add_rsp_t;

endpackage

//--- include/adder_settings.svh
// Datapath width settings shared by the add/subtract unit
`ifndef ADDER_SETTINGS_SVH
`define ADDER_SETTINGS_SVH

// Operand and result width
// Must be a power of two and at least 4
// The prefix tree takes its level count from this value
`define ADDER_WIDTH 32

`endif
